/* verilog/cpuPkg.sv */
// core package: word types, instruction encodings, ALU ops and core constants
`default_nettype none

package cpuPkg;

  // data, instruction and address words
  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE  = 6'h00,
    ADDIU  = 6'h09,
    ANDI   = 6'h0c,
    ORI    = 6'h0d,
    LUI    = 6'h0f,
    HALTOP = 6'h3f
  } opcodeT;

  // R-type funct field, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2a
  } functT;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,  // signed compare
    ALU_SLL,
    ALU_LUI   // operand B moved to the upper half
  } aluOpT;

  localparam wordT PC_INIT      = 32'h0000_0000;
  localparam wordT PC_STEP      = 32'd4;
  localparam wordT HALT_INSTR   = 32'hffff_ffff;
  localparam wordT BUBBLE_INSTR = 32'h0000_0000;  // sll r0,r0,0 so no write
  localparam int   REG_COUNT    = 32;

endpackage

`default_nettype wire

/* verilog/fetchUnit.sv */
// fetch stage: program counter and instruction request, stopped by halt
`timescale 1ns/1ns
`default_nettype none

module fetchUnit
  import cpuPkg::*;
(
  input  logic CLK,
  input  logic nRST,
  input  logic ihit,
  input  logic stall,
  input  logic halt,
  output logic imemREN,
  output wordT imemaddr,
  output wordT pc
);

  wordT pcReg;
  wordT pcNext;
  logic advance;

  // move on only with a valid word, no hazard and the core running
  assign advance = ihit & ~stall & ~halt;

  // sequential fetch only, no branches in this subset
  assign pcNext = pcReg + PC_STEP;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pcReg <= PC_INIT;
    end else if (advance) begin
      pcReg <= pcNext;
    end
  end

  // request stays up until the core halts
  assign imemREN  = ~halt;
  assign imemaddr = pcReg;
  assign pc       = pcReg;  // to decode

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
// register file: 32 x 32-bit, two combinational reads with write-through
`timescale 1ns/1ns
`default_nettype none

module registerFile
  import cpuPkg::*;
(
  input  logic   CLK,
  input  logic   nRST,
  input  logic   WEN,
  input  regIdxT wsel,
  input  wordT   wdat,
  input  regIdxT rsel1,
  input  regIdxT rsel2,
  output wordT   rdat1,
  output wordT   rdat2
);

  wordT regs [REG_COUNT];

  // register 0 stays zero because decode never writes it
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (WEN) begin
      regs[wsel] <= wdat;
    end
  end

  // same-cycle write is forwarded to the reader
  always_comb begin
    if (WEN && (wsel == rsel1)) begin
      rdat1 = wdat;
    end else begin
      rdat1 = regs[rsel1];
    end
  end

  always_comb begin
    if (WEN && (wsel == rsel2)) begin
      rdat2 = wdat;
    end else begin
      rdat2 = regs[rsel2];
    end
  end

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
// decode stage with IF/ID register, control decode, operand fetch and hazard stall
`timescale 1ns/1ns
`default_nettype none

module decodeStage
  import cpuPkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       ihit,
  input  wordT       imemload,
  input  wordT       pc,
  input  regIdxT     exDest,
  input  logic       exRegWrite,
  input  wordT       rdat1,
  input  wordT       rdat2,
  output regIdxT     rsel1,
  output regIdxT     rsel2,
  output logic       stall,
  output aluOpT      aluOp,
  output logic       aluSrc,
  output logic       shiftSel,
  output logic       regWrite,
  output logic       isHalt,
  output regIdxT     dest,
  output wordT       imm,
  output logic [4:0] shamt,
  output wordT       rdatA,
  output wordT       rdatB
);

  wordT   ifidInstr;
  opcodeT opcode;
  functT  funct;
  regIdxT rs;
  regIdxT rt;
  regIdxT rd;
  logic   writeD;
  logic   haltD;
  logic   zeroExt;
  logic   regDst;
  logic   readsA;
  logic   readsB;

  // IF/ID holds a bubble after reset
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ifidInstr <= BUBBLE_INSTR;
    end else if (ihit && !stall) begin
      ifidInstr <= imemload;
    end
  end

  assign opcode = opcodeT'(ifidInstr[31:26]);
  assign funct  = functT'(ifidInstr[5:0]);
  assign rs     = ifidInstr[25:21];
  assign rt     = ifidInstr[20:16];
  assign rd     = ifidInstr[15:11];
  assign shamt  = ifidInstr[10:6];

  always_comb begin
    aluOp    = ALU_ADD;
    aluSrc   = 1'b0;
    shiftSel = 1'b0;
    writeD   = 1'b0;
    haltD    = 1'b0;
    zeroExt  = 1'b0;
    regDst   = 1'b0;
    readsA   = 1'b0;
    readsB   = 1'b0;
    case (opcode)
      RTYPE: begin
        regDst = 1'b1;
        writeD = 1'b1;
        readsA = 1'b1;
        readsB = 1'b1;
        case (funct)
          SLL: begin
            aluOp    = ALU_SLL;
            shiftSel = 1'b1;
            readsB   = 1'b0;  // rt comes in on port A
          end
          ADDU: aluOp = ALU_ADD;
          SUBU: aluOp = ALU_SUB;
          AND:  aluOp = ALU_AND;
          OR:   aluOp = ALU_OR;
          XOR:  aluOp = ALU_XOR;
          SLT:  aluOp = ALU_SLT;
          default: begin
            writeD = 1'b0;  // unknown funct retires silently
            readsA = 1'b0;
            readsB = 1'b0;
          end
        endcase
      end
      ADDIU: begin
        aluSrc = 1'b1;
        writeD = 1'b1;
        readsA = 1'b1;
      end
      ANDI, ORI: begin
        aluOp   = (opcode == ANDI) ? ALU_AND : ALU_OR;
        aluSrc  = 1'b1;
        zeroExt = 1'b1;
        writeD  = 1'b1;
        readsA  = 1'b1;
      end
      LUI: begin
        aluOp   = ALU_LUI;
        aluSrc  = 1'b1;
        zeroExt = 1'b1;
        writeD  = 1'b1;
      end
      HALTOP: haltD = (ifidInstr == HALT_INSTR);
      default: ;
    endcase
  end

  // shifts read rt through port A
  assign rsel1 = shiftSel ? rt : rs;
  assign rsel2 = rt;
  assign rdatA = rdat1;
  assign rdatB = rdat2;

  assign dest = regDst ? rd : rt;
  assign imm  = zeroExt ? {16'h0000, ifidInstr[15:0]} : {{16{ifidInstr[15]}}, ifidInstr[15:0]};

  // only ID/EX can conflict as EX/WB goes through the write-through
  assign stall = exRegWrite && (exDest != '0) &&
                 ((readsA && (exDest == rsel1)) || (readsB && (exDest == rsel2)));

  // bubble downstream while stalled
  assign regWrite = writeD && (dest != '0) && !stall;
  assign isHalt   = haltD && !stall;

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
// execute stage: ID/EX and EX/WB registers, ALU, write-back and sticky halt
`timescale 1ns/1ns
`default_nettype none

module executeStage
  import cpuPkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       ihit,
  input  aluOpT      aluOp,
  input  logic       aluSrc,
  input  logic       shiftSel,
  input  logic       regWrite,
  input  logic       isHalt,
  input  regIdxT     dest,
  input  wordT       imm,
  input  logic [4:0] shamt,
  input  wordT       rdatA,
  input  wordT       rdatB,
  output regIdxT     exDest,
  output logic       exRegWrite,
  output logic       wbEn,
  output regIdxT     wbSel,
  output wordT       wbData,
  output logic       halt
);

  // ID/EX
  aluOpT      idexAluOp;
  logic       idexAluSrc;
  logic       idexShiftSel;
  logic       idexRegWrite;
  logic       idexIsHalt;
  regIdxT     idexDest;
  wordT       idexImm;
  logic [4:0] idexShamt;
  wordT       idexRdatA;
  wordT       idexRdatB;

  // EX/WB
  wordT   exwbResult;
  regIdxT exwbDest;
  logic   exwbRegWrite;
  logic   exwbIsHalt;

  wordT opB;
  wordT aluOut;
  logic advance;

  assign advance = ihit & ~halt;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      idexRegWrite <= 1'b0;
      idexIsHalt   <= 1'b0;
      exwbRegWrite <= 1'b0;
      exwbIsHalt   <= 1'b0;
    end else if (advance) begin
      idexRegWrite <= regWrite;
      idexIsHalt   <= isHalt;
      exwbRegWrite <= idexRegWrite;
      exwbIsHalt   <= idexIsHalt;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      idexAluOp    <= aluOp;
      idexAluSrc   <= aluSrc;
      idexShiftSel <= shiftSel;
      idexDest     <= dest;
      idexImm      <= imm;
      idexShamt    <= shamt;
      idexRdatA    <= rdatA;
      idexRdatB    <= rdatB;
      exwbResult   <= aluOut;
      exwbDest     <= idexDest;
    end
  end

  // operand B select
  always_comb begin
    if (idexShiftSel) begin
      opB = {27'b0, idexShamt};
    end else if (idexAluSrc) begin
      opB = idexImm;
    end else begin
      opB = idexRdatB;
    end
  end

  always_comb begin
    case (idexAluOp)
      ALU_ADD: aluOut = idexRdatA + opB;
      ALU_SUB: aluOut = idexRdatA - opB;
      ALU_AND: aluOut = idexRdatA & opB;
      ALU_OR:  aluOut = idexRdatA | opB;
      ALU_XOR: aluOut = idexRdatA ^ opB;
      ALU_SLT: aluOut = {31'b0, $signed(idexRdatA) < $signed(opB)};
      ALU_SLL: aluOut = idexRdatA << opB[4:0];
      ALU_LUI: aluOut = {opB[15:0], 16'h0000};
      default: aluOut = '0;
    endcase
  end

  // hazard view of ID/EX for decode
  assign exDest     = idexDest;
  assign exRegWrite = idexRegWrite;

  // retire at the next advancing edge
  assign wbEn   = exwbRegWrite & advance;
  assign wbSel  = exwbDest;
  assign wbData = exwbResult;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (exwbIsHalt && advance) begin
      halt <= 1'b1;  // sticky until reset
    end
  end

endmodule

`default_nettype wire

/* verilog/datapath.sv */
// core top: fetch, decode, register file and execute wired to the instruction port
`timescale 1ns/1ns
`default_nettype none

module datapath
  import cpuPkg::*;
(
  input  logic   CLK,
  input  logic   nRST,
  output logic   imemREN,
  output wordT   imemaddr,
  input  wordT   imemload,
  input  logic   ihit,
  output logic   wbEn,
  output regIdxT wbSel,
  output wordT   wbData,
  output logic   halt
);

  wordT       pc;
  logic       stall;
  regIdxT     rsel1;
  regIdxT     rsel2;
  wordT       rdat1;
  wordT       rdat2;

  // decoded bundle into execute
  aluOpT      aluOp;
  logic       aluSrc;
  logic       shiftSel;
  logic       regWrite;
  logic       isHalt;
  regIdxT     dest;
  wordT       imm;
  logic [4:0] shamt;
  wordT       rdatA;
  wordT       rdatB;

  regIdxT     exDest;
  logic       exRegWrite;

  fetchUnit i_fetchUnit (
    .CLK      (CLK),
    .nRST     (nRST),
    .ihit     (ihit),
    .stall    (stall),
    .halt     (halt),
    .imemREN  (imemREN),
    .imemaddr (imemaddr),
    .pc       (pc)
  );

  decodeStage i_decodeStage (
    .CLK        (CLK),
    .nRST       (nRST),
    .ihit       (ihit),
    .imemload   (imemload),
    .pc         (pc),
    .exDest     (exDest),
    .exRegWrite (exRegWrite),
    .rdat1      (rdat1),
    .rdat2      (rdat2),
    .rsel1      (rsel1),
    .rsel2      (rsel2),
    .stall      (stall),
    .aluOp      (aluOp),
    .aluSrc     (aluSrc),
    .shiftSel   (shiftSel),
    .regWrite   (regWrite),
    .isHalt     (isHalt),
    .dest       (dest),
    .imm        (imm),
    .shamt      (shamt),
    .rdatA      (rdatA),
    .rdatB      (rdatB)
  );

  // written from EX/WB, read by decode
  registerFile i_registerFile (
    .CLK   (CLK),
    .nRST  (nRST),
    .WEN   (wbEn),
    .wsel  (wbSel),
    .wdat  (wbData),
    .rsel1 (rsel1),
    .rsel2 (rsel2),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  executeStage i_executeStage (
    .CLK        (CLK),
    .nRST       (nRST),
    .ihit       (ihit),
    .aluOp      (aluOp),
    .aluSrc     (aluSrc),
    .shiftSel   (shiftSel),
    .regWrite   (regWrite),
    .isHalt     (isHalt),
    .dest       (dest),
    .imm        (imm),
    .shamt      (shamt),
    .rdatA      (rdatA),
    .rdatB      (rdatB),
    .exDest     (exDest),
    .exRegWrite (exRegWrite),
    .wbEn       (wbEn),
    .wbSel      (wbSel),
    .wbData     (wbData),
    .halt       (halt)
  );

endmodule

`default_nettype wire

/* tb/refModel.svh */
// ISA reference model: runs the program in order and lists the expected register writes
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

  function automatic void runReference();
    wordT        regs [REG_COUNT];
    wordT        instr;
    logic [5:0]  op;
    logic [5:0]  fn;
    regIdxT      rs;
    regIdxT      rt;
    regIdxT      rd;
    logic [4:0]  sh;
    logic [15:0] imm;
    wordT        rsVal;
    wordT        rtVal;
    wordT        result;
    regIdxT      target;
    logic        writes;
    for (int r = 0; r < REG_COUNT; r++) begin
      regs[r] = '0;
    end
    for (int idx = 0; idx < PROG_LEN; idx++) begin
      instr = progMem[idx];
      if (instr == HALT_INSTR) begin
        break;
      end
      op     = instr[31:26];
      rs     = instr[25:21];
      rt     = instr[20:16];
      rd     = instr[15:11];
      sh     = instr[10:6];
      fn     = instr[5:0];
      imm    = instr[15:0];
      rsVal  = regs[rs];
      rtVal  = regs[rt];
      result = '0;
      target = rt;  // I-type writes rt
      writes = 1'b1;
      case (op)
        RTYPE: begin
          target = rd;
          case (fn)
            SLL:  result = rtVal << sh;
            ADDU: result = rsVal + rtVal;
            SUBU: result = rsVal - rtVal;
            AND:  result = rsVal & rtVal;
            OR:   result = rsVal | rtVal;
            XOR:  result = rsVal ^ rtVal;
            SLT:  result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
            default: writes = 1'b0;
          endcase
        end
        ADDIU: result = rsVal + {{16{imm[15]}}, imm};
        ANDI:  result = rsVal & {16'h0000, imm};
        ORI:   result = rsVal | {16'h0000, imm};
        LUI:   result = {imm, 16'h0000};
        default: writes = 1'b0;  // no-op for anything else
      endcase
      // r0 stays zero and never shows up on the write port
      if (writes && (target != '0)) begin
        regs[target] = result;
        expSel.push_back(target);
        expData.push_back(result);
      end
    end
  endfunction

`endif

/* tb/datapathTb.sv */
// testbench for the pipelined core with random program, instruction memory and write-back compare
`timescale 1ns/1ns
`default_nettype none

module datapathTb
  import cpuPkg::*;
();

  localparam int          CLK_PERIOD  = 20;
  localparam int          PROG_LEN    = 64;
  localparam int          STAGES      = 4;
  localparam int          TIMEOUT_CYC = PROG_LEN * STAGES * 16;
  localparam int          QUIET_CYC   = 20;  // idle cycles checked after halt
  localparam logic [31:0] LFSR_SEED   = 32'd31;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic   CLK;
  logic   nRST;
  logic   ihit;
  wordT   imemload;
  logic   imemREN;
  wordT   imemaddr;
  logic   wbEn;
  regIdxT wbSel;
  wordT   wbData;
  logic   halt;

  wordT        progMem [PROG_LEN];
  regIdxT      expSel [$];  // expected writes in program order
  wordT        expData [$];
  logic [31:0] lfsrState;
  regIdxT      nextSel;
  wordT        nextData;

  datapath i_datapath (
    .CLK      (CLK),
    .nRST     (nRST),
    .imemREN  (imemREN),
    .imemaddr (imemaddr),
    .imemload (imemload),
    .ihit     (ihit),
    .wbEn     (wbEn),
    .wbSel    (wbSel),
    .wbData   (wbData),
    .halt     (halt)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic logic [31:0] stepLfsr(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = stepLfsr(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic wordT encodeR(input logic [5:0] fn, input regIdxT rs, input regIdxT rt,
                                   input regIdxT rd, input logic [4:0] sh);
    return {RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic wordT encodeI(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
                                   input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // registers r0..r7 only so neighbours often depend on each other
  task automatic buildProgram();
    logic [3:0]  kind;
    regIdxT      rs;
    regIdxT      rt;
    regIdxT      rd;
    logic [15:0] imm;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind = 4'(randBits(4));
      rs   = regIdxT'(randBits(3));
      rt   = regIdxT'(randBits(3));
      rd   = regIdxT'(randBits(3));
      imm  = 16'(randBits(16));
      case (kind)
        4'd0:  progMem[i] = encodeR(ADDU, rs, rt, rd, 5'd0);
        4'd1:  progMem[i] = encodeR(SUBU, rs, rt, rd, 5'd0);
        4'd2:  progMem[i] = encodeR(AND, rs, rt, rd, 5'd0);
        4'd3:  progMem[i] = encodeR(OR, rs, rt, rd, 5'd0);
        4'd4:  progMem[i] = encodeR(XOR, rs, rt, rd, 5'd0);
        4'd5:  progMem[i] = encodeR(SLT, rs, rt, rd, 5'd0);
        4'd6:  progMem[i] = encodeR(SLL, 5'd0, rt, rd, imm[4:0]);
        4'd9:  progMem[i] = encodeI(ANDI, rs, rt, imm);
        4'd10: progMem[i] = encodeI(ORI, rs, rt, imm);
        4'd11: progMem[i] = encodeI(LUI, 5'd0, rt, imm);
        4'd13: progMem[i] = encodeI(6'h23, rs, rt, imm);  // lw is outside the subset
        4'd14: progMem[i] = encodeR(6'h08, rs, rt, rd, 5'd0);  // jr funct is unsupported
        4'd15: progMem[i] = encodeI(ADDIU, 5'd0, rt, imm);  // load immediate
        default: progMem[i] = encodeI(ADDIU, rs, rt, imm);
      endcase
    end
    progMem[PROG_LEN - 1] = HALT_INSTR;
  endtask

  `include "refModel.svh"

  // past the end of the program the memory answers with halts
  function automatic wordT fetchWord(input wordT addr);
    if ((addr >> 2) < PROG_LEN) begin
      return progMem[addr >> 2];
    end
    return HALT_INSTR;
  endfunction

  task automatic checkReg(input string name, input regIdxT actual, input regIdxT expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkWord(input string name, input wordT actual, input wordT expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // instruction memory with one word per hit then a gap so the pc can move
  always @(posedge CLK) begin
    if (!nRST || imemREN !== 1'b1) begin
      ihit <= 1'b0;
    end else if (ihit) begin
      ihit <= 1'b0;
    end else begin
      imemload <= fetchWord(imemaddr);
      ihit     <= randBits(1) != 0;  // random wait states
    end
  end

  // write-back compare against the reference list
  always @(posedge CLK) begin
    if (wbEn) begin
      if (expSel.size() == 0) begin
        $display("write to r%0d retired with no write left in the expected list", wbSel);
        $display("TEST FAILED");
        $fatal(1);
      end else begin
        nextSel  = expSel.pop_front();
        nextData = expData.pop_front();
        checkReg("wbSel", wbSel, nextSel);
        checkWord("wbData", wbData, nextData);
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge CLK);
    $display("timeout: the core never halted within %0d cycles", TIMEOUT_CYC);
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    nRST      = 1'b0;
    ihit      = 1'b0;
    imemload  = '0;
    lfsrState = LFSR_SEED;
    buildProgram();
    runReference();
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    // ihit still low here so nothing has moved
    checkBit("wbEn", wbEn, 1'b0);
    checkBit("halt", halt, 1'b0);
    checkBit("imemREN", imemREN, 1'b1);
    checkWord("imemaddr", imemaddr, PC_INIT);
    while (halt !== 1'b1) begin
      @(posedge CLK);
    end
    if (expSel.size() != 0) begin
      $display("core halted with %0d expected writes never seen", expSel.size());
      $display("TEST FAILED");
      $fatal(1);
    end
    repeat (QUIET_CYC) begin
      @(posedge CLK);
      checkBit("imemREN", imemREN, 1'b0);
      checkBit("wbEn", wbEn, 1'b0);
      checkBit("halt", halt, 1'b1);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tb
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/registerFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/datapath.sv
tb/datapathTb.sv
